// ==== logic/eth_stream_pkg.sv ====
/* Stream beat and GMII lane types plus the Ethernet CRC-32.
   CRC is the reflected form (poly 0xEDB88320, init all ones), FCS = ~crc LSB first */
`default_nettype none

package eth_stream_pkg;

  // One 64-bit stream beat, first byte in data[7:0]
  typedef struct packed {
    logic [63:0] data;
    logic        last;
    logic [2:0]  nbytes;  // Valid bytes in last beat, 0 means 8
  } eth_beat_t;

  // One GMII byte lane
  typedef struct packed {
    logic [7:0] data;
    logic       en;
    logic       er;
  } gmii_t;

  localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0]  SFD_BYTE      = 8'hD5;
  localparam logic [31:0] CRC_RESIDUE   = 32'hDEBB20E3;  // Register value after data plus FCS

  // Advance the running CRC by one byte, LSB first
  function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] d);
    logic [31:0] c;
    int          i;
    c = crc ^ {24'h0, d};
    for (i = 0; i < 8; i++)
      c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
    return c;
  endfunction

endpackage

`default_nettype wire

// ==== logic/gige_loopback_top.sv ====
/* Near-end and far-end MACs joined by two crossed GMII links, no PHY model.
   The far end sends every good frame straight back */
`timescale 1ns/1ns
`default_nettype none

module gige_loopback_top #(
  parameter int FIFO_BEATS = 64,
  parameter int MAX_BEATS  = 32   // Not above FIFO_BEATS
) (
  input  wire logic                      arst_n_i,
  input  wire logic                      m_user_clk,
  input  wire eth_stream_pkg::eth_beat_t tx_beat_i,
  input  wire logic                      tx_valid_i,
  output logic                           tx_ready_o,
  output eth_stream_pkg::eth_beat_t      rx_beat_o,
  output logic                           rx_valid_o,
  input  wire logic                      rx_ready_i,
  input  wire mac_regs_pkg::wb_req_t     m_wb_i,
  output mac_regs_pkg::wb_rsp_t          m_wb_o,
  input  wire mac_regs_pkg::wb_req_t     s_wb_i,
  output mac_regs_pkg::wb_rsp_t          s_wb_o
);
  import eth_stream_pkg::*;

  gmii_t     near_to_far, far_to_near;  // Crossed GMII links
  eth_beat_t loop_beat;                 // Far-end RX back into far-end TX
  logic      loop_valid, loop_ready;

  // ------------------------------
  // User side MAC
  // ------------------------------
  gige_mac #(.FIFO_BEATS(FIFO_BEATS), .MAX_BEATS(MAX_BEATS)) near_mac (
    .arst_n_i   (arst_n_i),
    .m_user_clk (m_user_clk),
    .tx_beat_i  (tx_beat_i),
    .tx_valid_i (tx_valid_i),
    .tx_ready_o (tx_ready_o),
    .rx_beat_o  (rx_beat_o),
    .rx_valid_o (rx_valid_o),
    .rx_ready_i (rx_ready_i),
    .gmii_tx_o  (near_to_far),
    .gmii_rx_i  (far_to_near),
    .wb_i       (m_wb_i),
    .wb_o       (m_wb_o)
  );

  // Loopback MAC
  gige_mac #(.FIFO_BEATS(FIFO_BEATS), .MAX_BEATS(MAX_BEATS)) far_mac (
    .arst_n_i   (arst_n_i),
    .m_user_clk (m_user_clk),
    .tx_beat_i  (loop_beat),
    .tx_valid_i (loop_valid),
    .tx_ready_o (loop_ready),
    .rx_beat_o  (loop_beat),
    .rx_valid_o (loop_valid),
    .rx_ready_i (loop_ready),
    .gmii_tx_o  (far_to_near),
    .gmii_rx_i  (near_to_far),
    .wb_i       (s_wb_i),
    .wb_o       (s_wb_o)
  );

endmodule

`default_nettype wire

// ==== logic/gige_mac.sv ====
/* One MAC: stream to GMII framer, GMII to stream deframer and counter block.
   Underrun frames count as sent frames */
`timescale 1ns/1ns
`default_nettype none

module gige_mac #(
  parameter int FIFO_BEATS = 64,
  parameter int MAX_BEATS  = 32
) (
  input  wire logic                      arst_n_i,
  input  wire logic                      m_user_clk,
  input  wire eth_stream_pkg::eth_beat_t tx_beat_i,
  input  wire logic                      tx_valid_i,
  output logic                           tx_ready_o,
  output eth_stream_pkg::eth_beat_t      rx_beat_o,
  output logic                           rx_valid_o,
  input  wire logic                      rx_ready_i,
  output eth_stream_pkg::gmii_t          gmii_tx_o,
  input  wire eth_stream_pkg::gmii_t     gmii_rx_i,
  input  wire mac_regs_pkg::wb_req_t     wb_i,
  output mac_regs_pkg::wb_rsp_t          wb_o
);

  logic frame_sent, underrun, tx_frame_evt;
  logic rx_good, rx_bad, rx_drop;

  assign tx_frame_evt = frame_sent | underrun;  // Both end a frame on the wire

  gmii_tx_framer framer0 (
    .arst_n_i     (arst_n_i),
    .m_user_clk   (m_user_clk),
    .in_beat_i    (tx_beat_i),
    .in_valid_i   (tx_valid_i),
    .in_ready_o   (tx_ready_o),
    .gmii_o       (gmii_tx_o),
    .frame_sent_o (frame_sent),
    .underrun_o   (underrun)
  );

  gmii_rx_deframer #(
    .FIFO_BEATS (FIFO_BEATS),
    .MAX_BEATS  (MAX_BEATS)
  ) deframer0 (
    .arst_n_i    (arst_n_i),
    .m_user_clk  (m_user_clk),
    .gmii_i      (gmii_rx_i),
    .out_beat_o  (rx_beat_o),
    .out_valid_o (rx_valid_o),
    .out_ready_i (rx_ready_i),
    .rx_good_o   (rx_good),
    .rx_bad_o    (rx_bad),
    .rx_drop_o   (rx_drop)
  );

  mac_wb_regs regs0 (
    .arst_n_i     (arst_n_i),
    .m_user_clk   (m_user_clk),
    .wb_i         (wb_i),
    .wb_o         (wb_o),
    .frame_sent_i (tx_frame_evt),
    .rx_good_i    (rx_good),
    .rx_bad_i     (rx_bad),
    .rx_drop_i    (rx_drop)
  );

endmodule

`default_nettype wire

// ==== logic/gmii_rx_deframer.sv ====
/* GMII bytes to beats through a frame-commit FIFO; only FCS-clean frames come out.
   FIFO_BEATS must be a power of two and MAX_BEATS <= FIFO_BEATS.
   Oversize frames are dropped and counted with the FIFO-full drops */
`timescale 1ns/1ns
`default_nettype none

module gmii_rx_deframer #(
  parameter int FIFO_BEATS = 64,
  parameter int MAX_BEATS  = 32
) (
  input  wire logic                  arst_n_i,
  input  wire logic                  m_user_clk,
  input  wire eth_stream_pkg::gmii_t gmii_i,
  output eth_stream_pkg::eth_beat_t  out_beat_o,
  output logic                       out_valid_o,
  input  wire logic                  out_ready_i,
  output logic                       rx_good_o,
  output logic                       rx_bad_o,
  output logic                       rx_drop_o
);
  import eth_stream_pkg::*;

  localparam int          AW       = $clog2(FIFO_BEATS);
  localparam logic [AW:0] FIFO_LVL = (AW+1)'(FIFO_BEATS);
  localparam logic [AW:0] MAX_LVL  = (AW+1)'(MAX_BEATS);

  typedef enum logic {S_HUNT, S_DATA} rx_state_e;

  rx_state_e   state_q;
  eth_beat_t   mem [FIFO_BEATS];
  logic [AW:0] wr_q;        // Tentative write pointer
  logic [AW:0] commit_q;    // End of last good frame
  logic [AW:0] rd_q;
  logic [31:0] crc_q;
  logic [31:0] dly_q;       // Last 4 bytes, oldest in [7:0]
  logic [2:0]  dly_cnt_q;
  logic [63:0] acc_q;       // Beat being packed
  logic [3:0]  acc_cnt_q;   // Bytes in acc_q, 0..8
  logic        err_q;
  logic        drop_q;

  logic        byte_vld, pay_vld, eof;
  logic        wr_req, wr_fail, wr_en, drop_now, good;
  logic [AW:0] used, frame_len;
  eth_beat_t   wr_beat;

  // ------------------------------
  // Byte flow
  // ------------------------------
  assign byte_vld = (state_q == S_DATA) && gmii_i.en;
  assign pay_vld  = byte_vld && (dly_cnt_q == 3'd4);  // FCS bytes never leave dly_q
  assign eof      = (state_q == S_DATA) && !gmii_i.en;

  // A full beat is written only once a further payload byte proves it is not the last
  assign wr_req    = (pay_vld && (acc_cnt_q == 4'd8)) || (eof && (acc_cnt_q != 4'd0));
  assign used      = wr_q - rd_q;
  assign frame_len = wr_q - commit_q;
  assign wr_fail   = wr_req && ((used == FIFO_LVL) || (frame_len == MAX_LVL));
  assign wr_en     = wr_req && !wr_fail && !drop_q;

  assign wr_beat = '{data: acc_q, last: eof, nbytes: eof ? acc_cnt_q[2:0] : 3'd0};

  // Frame verdict, valid on eof only
  assign drop_now  = drop_q || wr_fail;
  assign good      = eof && !drop_now && !err_q && (crc_q == CRC_RESIDUE) &&
                     (acc_cnt_q != 4'd0);
  assign rx_good_o = good;
  assign rx_drop_o = eof && drop_now;
  assign rx_bad_o  = eof && !drop_now && !good;

  // Read side sees committed beats only
  assign out_valid_o = (rd_q != commit_q);
  assign out_beat_o  = mem[rd_q[AW-1:0]];

  // ------------------------------
  // Control
  // ------------------------------
  always_ff @(posedge m_user_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q   <= S_HUNT;
      wr_q      <= '0;
      commit_q  <= '0;
      rd_q      <= '0;
      dly_cnt_q <= 3'd0;
      acc_cnt_q <= 4'd0;
      err_q     <= 1'b0;
      drop_q    <= 1'b0;
    end
    else
    begin
      if (out_valid_o && out_ready_i)
        rd_q <= rd_q + 1'b1;
      case (state_q)
        S_HUNT:
          if (gmii_i.en && (gmii_i.data == SFD_BYTE))
          begin
            state_q   <= S_DATA;
            dly_cnt_q <= 3'd0;
            acc_cnt_q <= 4'd0;
            err_q     <= 1'b0;
            drop_q    <= 1'b0;
          end
        default:
        begin
          if (byte_vld && (dly_cnt_q != 3'd4))
            dly_cnt_q <= dly_cnt_q + 3'd1;
          if (byte_vld && gmii_i.er)
            err_q <= 1'b1;
          if (pay_vld)
            acc_cnt_q <= (acc_cnt_q == 4'd8) ? 4'd1 : acc_cnt_q + 4'd1;
          if (wr_fail)
            drop_q <= 1'b1;
          if (wr_en)
            wr_q <= wr_q + 1'b1;
          if (eof)
          begin
            state_q <= S_HUNT;
            if (good)
              commit_q <= wr_q + 1'b1;  // Includes the final beat
            else
              wr_q <= commit_q;         // Roll back the whole frame
          end
        end
      endcase
    end
  end

  // ------------------------------
  // Datapath
  // ------------------------------
  always_ff @(posedge m_user_clk)
  begin
    if (state_q == S_HUNT)
      crc_q <= '1;
    else if (byte_vld)
      crc_q <= crc32_byte(crc_q, gmii_i.data);  // Runs over FCS too
    if (byte_vld)
      dly_q <= {gmii_i.data, dly_q[31:8]};
    if (pay_vld)
      acc_q[{acc_cnt_q[2:0], 3'b000} +: 8] <= dly_q[7:0];  // Slot 0 when acc was full
    if (wr_en)
      mem[wr_q[AW-1:0]] <= wr_beat;
  end

endmodule

`default_nettype wire

// ==== logic/gmii_tx_framer.sv ====
/* Beats to GMII bytes: 7 preamble, SFD, payload, 4 FCS bytes, then 12 idle cycles.
   ready is only raised when the next beat is due; a missing beat mid-frame ends
   the frame early with er set across its FCS */
`timescale 1ns/1ns
`default_nettype none

module gmii_tx_framer (
  input  wire logic                      arst_n_i,
  input  wire logic                      m_user_clk,
  input  wire eth_stream_pkg::eth_beat_t in_beat_i,
  input  wire logic                      in_valid_i,
  output logic                           in_ready_o,
  output eth_stream_pkg::gmii_t          gmii_o,
  output logic                           frame_sent_o,
  output logic                           underrun_o
);
  import eth_stream_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_PRE, S_DATA, S_FCS, S_GAP} tx_state_e;

  tx_state_e   state_q;
  eth_beat_t   beat_q;     // Beat on the wire
  logic [2:0]  byte_q;     // Byte index inside beat_q
  logic [3:0]  cnt_q;      // Preamble / FCS / gap counter
  logic [31:0] crc_q;
  logic        under_q;    // Frame cut short

  logic [7:0]  data_byte;
  logic [2:0]  last_idx;
  logic        beat_end;

  assign data_byte = beat_q.data[{byte_q, 3'b000} +: 8];
  assign last_idx  = beat_q.nbytes - 3'd1;  // 0 wraps to 7, full beat
  assign beat_end  = beat_q.last ? (byte_q == last_idx) : (byte_q == 3'd7);

  // Take a beat when idle, or on the last byte of a non-final beat
  assign in_ready_o = (state_q == S_IDLE) ||
                      ((state_q == S_DATA) && beat_end && !beat_q.last);

  // End of frame events
  assign frame_sent_o = (state_q == S_FCS) && (cnt_q == 4'd3) && !under_q;
  assign underrun_o   = (state_q == S_FCS) && (cnt_q == 4'd3) && under_q;

  // ------------------------------
  // Lane driver
  // ------------------------------
  always_comb
  begin
    gmii_o = '0;
    case (state_q)
      S_PRE:
      begin
        gmii_o.en   = 1'b1;
        gmii_o.data = (cnt_q == 4'd7) ? SFD_BYTE : PREAMBLE_BYTE;
      end
      S_DATA:
      begin
        gmii_o.en   = 1'b1;
        gmii_o.data = data_byte;
      end
      S_FCS:
      begin
        gmii_o.en   = 1'b1;
        gmii_o.er   = under_q;  // Poisons the frame at the far end
        gmii_o.data = ~crc_q[{cnt_q[1:0], 3'b000} +: 8];
      end
      default:
        gmii_o = '0;
    endcase
  end

  // ------------------------------
  // Frame FSM
  // ------------------------------
  always_ff @(posedge m_user_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= S_GAP;  // Full gap before the first frame
      cnt_q   <= 4'd0;
      byte_q  <= 3'd0;
      under_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        S_IDLE:
          if (in_valid_i)
          begin
            state_q <= S_PRE;
            cnt_q   <= 4'd0;
            under_q <= 1'b0;
          end
        S_PRE:
        begin
          cnt_q <= cnt_q + 4'd1;
          if (cnt_q == 4'd7)
          begin
            state_q <= S_DATA;
            byte_q  <= 3'd0;
          end
        end
        S_DATA:
        begin
          byte_q <= byte_q + 3'd1;
          if (beat_end)
          begin
            byte_q <= 3'd0;
            if (beat_q.last || !in_valid_i)
            begin
              state_q <= S_FCS;
              cnt_q   <= 4'd0;
              under_q <= !beat_q.last;  // Next beat missing
            end
          end
        end
        S_FCS:
        begin
          cnt_q <= cnt_q + 4'd1;
          if (cnt_q == 4'd3)
          begin
            state_q <= S_GAP;
            cnt_q   <= 4'd0;
          end
        end
        default:  // S_GAP, 12 cycles
        begin
          cnt_q <= cnt_q + 4'd1;
          if (cnt_q == 4'd11)
            state_q <= S_IDLE;
        end
      endcase
    end
  end

  // Held beat and running CRC
  always_ff @(posedge m_user_clk)
  begin
    if (in_valid_i && in_ready_o)
      beat_q <= in_beat_i;
    if (state_q == S_PRE)
      crc_q <= '1;
    else if (state_q == S_DATA)
      crc_q <= crc32_byte(crc_q, data_byte);
  end

endmodule

`default_nettype wire

// ==== logic/mac_regs_pkg.sv ====
/* Wishbone classic request/response and the MAC counter map.
   All counters are read-only; a write to a counter address clears it */
`default_nettype none

package mac_regs_pkg;

  // Master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // ------------------------------
  // Counter map, byte offsets
  // ------------------------------
  localparam logic [3:0] REG_TX_FRAMES = 4'h0;  // Frames sent, underruns included
  localparam logic [3:0] REG_RX_GOOD   = 4'h4;  // Frames passed FCS check
  localparam logic [3:0] REG_RX_BAD    = 4'h8;  // Bad FCS or er seen
  localparam logic [3:0] REG_RX_DROP   = 4'hC;  // No room in the receive FIFO

endpackage

`default_nettype wire

// ==== logic/mac_wb_regs.sv ====
/* Wishbone classic slave with four 32-bit event counters.
   One ack per request, 1 cycle after it; a write clears the addressed counter */
`timescale 1ns/1ns
`default_nettype none

module mac_wb_regs (
  input  wire logic                   arst_n_i,
  input  wire logic                   m_user_clk,
  input  wire mac_regs_pkg::wb_req_t  wb_i,
  output mac_regs_pkg::wb_rsp_t       wb_o,
  input  wire logic                   frame_sent_i,
  input  wire logic                   rx_good_i,
  input  wire logic                   rx_bad_i,
  input  wire logic                   rx_drop_i
);
  import mac_regs_pkg::*;

  logic [31:0] cnt_q [4];
  logic [3:0]  evt;
  logic [1:0]  sel;       // Counter slot
  logic        hit;       // Address maps to a counter
  logic        req;
  logic        ack_q;
  logic [31:0] dat_q;

  assign evt = {rx_drop_i, rx_bad_i, rx_good_i, frame_sent_i};  // Same order as sel
  assign req = wb_i.cyc && wb_i.stb && !ack_q;  // Master still holds stb on the ack cycle

  // Address decode
  always_comb
  begin
    hit = 1'b1;
    sel = 2'd0;
    case (wb_i.adr)
      REG_TX_FRAMES: sel = 2'd0;
      REG_RX_GOOD:   sel = 2'd1;
      REG_RX_BAD:    sel = 2'd2;
      REG_RX_DROP:   sel = 2'd3;
      default:       hit = 1'b0;
    endcase
  end

  always_ff @(posedge m_user_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q <= 1'b0;
      for (int i = 0; i < 4; i++)
        cnt_q[i] <= '0;
    end
    else
    begin
      ack_q <= req;
      for (int i = 0; i < 4; i++)
      begin
        if (req && wb_i.we && hit && (sel == 2'(i)))
          cnt_q[i] <= '0;  // Clear beats a same-cycle event
        else if (evt[i])
          cnt_q[i] <= cnt_q[i] + 32'd1;
      end
    end
  end

  // Read data, unmapped reads as zero
  always_ff @(posedge m_user_clk)
  begin
    if (req)
      dat_q <= hit ? cnt_q[sel] : 32'd0;
  end

  assign wb_o = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loopback testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module gige_loopback_tb \
  -Mdir obj_dir -o gige_loopback_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/gige_loopback_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== sim.f ====
logic/eth_stream_pkg.sv
logic/mac_regs_pkg.sv
logic/gmii_tx_framer.sv
logic/gmii_rx_deframer.sv
logic/mac_wb_regs.sv
logic/gige_mac.sv
logic/gige_loopback_top.sv
sim/loopback_checker.sv
sim/gige_loopback_tb.sv

// ==== sim/gige_loopback_tb.sv ====
/* Loopback testbench reading records from sim/loopback_stimulus.txt; run from the project root.
   Inputs change 1 ns after the rising edge; the watchdog limit grows per record */
`timescale 1ns/1ns
`default_nettype none

module gige_loopback_tb;
  import eth_stream_pkg::*;
  import mac_regs_pkg::*;

  logic         m_user_clk;
  logic         arst_n_i;
  eth_beat_t    tx_beat;
  logic         tx_valid, tx_ready_o;
  eth_beat_t    rx_beat_o;
  logic         rx_valid_o, rx_ready;
  wb_req_t      m_wb_r, s_wb_r;
  wb_rsp_t      m_wb_o, s_wb_o;

  // Checker side channels
  logic         exp_stb, vchk_stb;
  logic [127:0] exp_name, vchk_name;
  logic [15:0]  exp_len;
  logic [31:0]  exp_seed, vchk_exp, vchk_act;
  int           mismatches, others, pending;

  int           ready_mode = 0;        // 0 low, 1 high, 2 random
  logic [31:0]  rdy_rnd = 32'h8d8b;
  int           cycles = 0;
  int           limit = 2000;
  int           tx_total = 0;          // Near-end frames put on the wire
  int           good_total = 0;        // Frames expected back
  int           run_errs = 0;          // Missing frames or unreadable file

  gige_loopback_top #(.FIFO_BEATS(64), .MAX_BEATS(32)) dut0 (
    .arst_n_i   (arst_n_i),
    .m_user_clk (m_user_clk),
    .tx_beat_i  (tx_beat),
    .tx_valid_i (tx_valid),
    .tx_ready_o (tx_ready_o),
    .rx_beat_o  (rx_beat_o),
    .rx_valid_o (rx_valid_o),
    .rx_ready_i (rx_ready),
    .m_wb_i     (m_wb_r),
    .m_wb_o     (m_wb_o),
    .s_wb_i     (s_wb_r),
    .s_wb_o     (s_wb_o)
  );

  loopback_checker chk0 (
    .m_user_clk (m_user_clk),
    .rx_beat_i  (rx_beat_o),
    .rx_valid_i (rx_valid_o),
    .rx_ready_i (rx_ready),
    .exp_stb_i  (exp_stb),
    .exp_name_i (exp_name),
    .exp_len_i  (exp_len),
    .exp_seed_i (exp_seed),
    .vchk_stb_i (vchk_stb),
    .vchk_name_i(vchk_name),
    .vchk_exp_i (vchk_exp),
    .vchk_act_i (vchk_act),
    .mismatch_o (mismatches),
    .other_o    (others),
    .pending_o  (pending)
  );

  always #2 m_user_clk = ~m_user_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Returned-stream ready pattern
  always @(posedge m_user_clk)
  begin
    #1;
    case (ready_mode)
      0: rx_ready = 1'b0;
      1: rx_ready = 1'b1;
      default:
      begin
        rdy_rnd  = lcg_next(rdy_rnd);
        rx_ready = rdy_rnd[16];
      end
    endcase
  end

  // ------------------------------
  // Watchdog
  // ------------------------------
  always @(posedge m_user_clk)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("ERROR: run did not finish within %0d cycles", limit);
      $display("Errors: %0d mismatch, %0d other, 1 timeout", mismatches, others + run_errs);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Hand one value to the checker for one cycle
  task automatic check_value(input logic [127:0] nm, input logic [31:0] e, input logic [31:0] a);
    vchk_name = nm;
    vchk_exp  = e;
    vchk_act  = a;
    vchk_stb  = 1'b1;
    @(posedge m_user_clk);
    #1 vchk_stb = 1'b0;
  endtask

  // Wishbone classic single access
  task automatic wb_access(input logic far, input logic we, input logic [3:0] adr,
                           output logic [31:0] dat);
    wb_req_t req;
    req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: 32'd0};
    if (far)
      s_wb_r = req;
    else
      m_wb_r = req;
    @(negedge m_user_clk);
    while (!(far ? s_wb_o.ack : m_wb_o.ack))
      @(negedge m_user_clk);
    dat = far ? s_wb_o.dat : m_wb_o.dat;  // Valid with ack
    @(posedge m_user_clk);
    #1;
    m_wb_r = '0;
    s_wb_r = '0;
  endtask

  task automatic wait_tx_ready(input logic level);
    @(negedge m_user_clk);
    while (tx_ready_o !== level)
      @(negedge m_user_clk);
  endtask

  // ------------------------------
  // Stream driver
  // ------------------------------
  task automatic send_frame(input int len, inout logic [31:0] rnd, input int cut);
    eth_beat_t beat;
    int        nbeats;
    nbeats = (len + 7) / 8;
    for (int b = 0; b < nbeats; b++)
    begin
      beat = '0;
      for (int i = 0; i < 8; i++)
      begin
        if (b * 8 + i < len)
        begin
          rnd                  = lcg_next(rnd);
          beat.data[i*8 +: 8]  = rnd[23:16];
        end
      end
      beat.last   = (b == nbeats - 1);
      beat.nbytes = 3'(len % 8);
      tx_beat     = beat;
      tx_valid    = 1'b1;
      wait_tx_ready(1'b1);  // Taken on the next edge
      @(posedge m_user_clk);
      #1;
      if ((cut != 0) && (b + 1 == cut))
        break;
    end
    tx_valid = 1'b0;
    if (cut != 0)
    begin
      wait_tx_ready(1'b1);  // Missed beat slot starts the underrun
      wait_tx_ready(1'b0);
      wait_tx_ready(1'b1);  // Back to idle after the gap
      @(posedge m_user_clk);
      #1;
    end
  endtask

  task automatic wait_returned;
    while (pending != 0)
    begin
      @(posedge m_user_clk);
      #1;
    end
  endtask

  // Main sequence
  initial
  begin
    int           fd, code, frames, len, rmode, cut;
    int           n_tx, f_good, f_tx, n_good, f_bad;
    string        cmd;
    logic [127:0] name;
    logic [1599:0] line;
    logic [31:0]  seed, rnd, dat;
    m_user_clk = 1'b0;
    arst_n_i   = 1'b0;
    tx_beat    = '0;
    tx_valid   = 1'b0;
    rx_ready   = 1'b0;
    m_wb_r     = '0;
    s_wb_r     = '0;
    exp_stb    = 1'b0;
    exp_name   = '0;
    exp_len    = '0;
    exp_seed   = '0;
    vchk_stb   = 1'b0;
    vchk_name  = '0;
    vchk_exp   = '0;
    vchk_act   = '0;
    repeat (10) @(posedge m_user_clk);
    #1 arst_n_i = 1'b1;
    check_value("reset_tx_ready", 32'd0, {31'd0, tx_ready_o});
    check_value("reset_rx_valid", 32'd0, {31'd0, rx_valid_o});
    for (int f = 0; f < 2; f++)
    begin
      for (int a = 0; a < 16; a += 4)
      begin
        wb_access(f[0], 1'b0, 4'(a), dat);
        check_value("reset_counter", 32'd0, dat);
      end
    end

    fd = $fopen("sim/loopback_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open sim/loopback_stimulus.txt");
      run_errs++;
    end
    while ((fd != 0) && !$feof(fd))
    begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1)
        break;
      if (cmd == "#")
        code = $fgets(line, fd);  // Column notes
      else if (cmd == "frame")
      begin
        code = $fscanf(fd, "%s %d %d %h %d %d", name, frames, len, seed, rmode, cut);
        limit += frames * (40 + 3 * len);
        ready_mode = rmode;
        rnd = seed;                 // Reseed per record
        for (int f = 0; f < frames; f++)
        begin
          if (!((cut != 0) && (f == 0)))
          begin
            exp_name = name;
            exp_len  = 16'(len);
            exp_seed = rnd;
            exp_stb  = 1'b1;
            @(posedge m_user_clk);
            #1 exp_stb = 1'b0;
            good_total++;
          end
          send_frame(len, rnd, (f == 0) ? cut : 0);
          tx_total++;
        end
        if (rmode != 0)
          wait_returned();
      end
      else if (cmd == "drain")
      begin
        code = $fscanf(fd, "%s", name);
        dat = 32'd0;
        while (dat != 32'(good_total))  // All frames parked in the near FIFO
          wb_access(1'b0, 1'b0, REG_RX_GOOD, dat);
        ready_mode = 1;
        wait_returned();
      end
      else if (cmd == "check")
      begin
        code = $fscanf(fd, "%s %d %d %d %d %d", name, n_tx, f_good, f_tx, n_good, f_bad);
        check_value("tb_tx_count", 32'(n_tx), 32'(tx_total));
        wb_access(1'b0, 1'b0, REG_TX_FRAMES, dat);
        check_value("near_tx_frames", 32'(n_tx), dat);
        wb_access(1'b1, 1'b0, REG_RX_GOOD, dat);
        check_value("far_rx_good", 32'(f_good), dat);
        wb_access(1'b1, 1'b0, REG_TX_FRAMES, dat);
        check_value("far_tx_frames", 32'(f_tx), dat);
        wb_access(1'b0, 1'b0, REG_RX_GOOD, dat);
        check_value("near_rx_good", 32'(n_good), dat);
        wb_access(1'b1, 1'b0, REG_RX_BAD, dat);
        check_value("far_rx_bad", 32'(f_bad), dat);
        // Clear hits one counter only
        wb_access(1'b0, 1'b1, REG_TX_FRAMES, dat);
        wb_access(1'b0, 1'b0, REG_TX_FRAMES, dat);
        check_value("near_tx_cleared", 32'd0, dat);
        wb_access(1'b0, 1'b0, REG_RX_GOOD, dat);
        check_value("near_good_kept", 32'(n_good), dat);
        wb_access(1'b1, 1'b1, REG_RX_BAD, dat);
        wb_access(1'b1, 1'b0, REG_RX_BAD, dat);
        check_value("far_bad_cleared", 32'd0, dat);
        wb_access(1'b1, 1'b0, REG_RX_GOOD, dat);
        check_value("far_good_kept", 32'(f_good), dat);
      end
    end
    if (fd != 0)
      $fclose(fd);
    repeat (4) @(posedge m_user_clk);
    #1;
    if (pending != 0)
    begin
      $display("ERROR: %0d expected frames never returned", pending);
      run_errs++;
    end
    $display("Errors: %0d mismatch, %0d other, 0 timeout", mismatches, others + run_errs);
    if ((mismatches == 0) && (others == 0) && (run_errs == 0))
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/loopback_checker.sv ====
/* Returned-stream scoreboard and value comparator for the loopback testbench.
   Expected frames are queued as (name, length, LCG state); bytes are regenerated here */
`timescale 1ns/1ns
`default_nettype none

module loopback_checker (
  input  wire logic                      m_user_clk,
  input  wire eth_stream_pkg::eth_beat_t rx_beat_i,
  input  wire logic                      rx_valid_i,
  input  wire logic                      rx_ready_i,
  input  wire logic                      exp_stb_i,    // Queue one expected frame
  input  wire logic [127:0]              exp_name_i,
  input  wire logic [15:0]               exp_len_i,
  input  wire logic [31:0]               exp_seed_i,
  input  wire logic                      vchk_stb_i,   // Compare one value
  input  wire logic [127:0]              vchk_name_i,
  input  wire logic [31:0]               vchk_exp_i,
  input  wire logic [31:0]               vchk_act_i,
  output int                             mismatch_o,
  output int                             other_o,
  output int                             pending_o
);
  import eth_stream_pkg::*;

  logic [127:0] name_q [$];   // Outstanding frames, oldest first
  int           len_q  [$];
  logic [31:0]  seed_q [$];
  logic [31:0]  rnd;          // Byte generator state
  int           byte_idx;     // Bytes already checked in the head frame
  logic         hold_q;       // Beat offered but not taken
  eth_beat_t    held_q;

  // Same LCG as the stimulus side
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // ------------------------------
  // One returned beat
  // ------------------------------
  task automatic check_beat(input eth_beat_t b);
    logic [63:0] exp_d;
    logic [63:0] mask;
    logic        exp_last;
    logic [2:0]  exp_nb;
    int          left;
    if (len_q.size() == 0)
    begin
      other_o++;
      $display("ERROR: returned beat with no frame outstanding, data %h", b.data);
      return;
    end
    if (byte_idx == 0)
      rnd = seed_q[0];
    left  = len_q[0] - byte_idx;
    exp_d = '0;
    mask  = '0;
    for (int i = 0; i < 8; i++)
    begin
      if (i < left)
      begin
        rnd               = next_rand(rnd);
        exp_d[i*8 +: 8]   = rnd[23:16];
        mask[i*8 +: 8]    = 8'hFF;
      end
    end
    exp_last = (left <= 8);
    exp_nb   = 3'(len_q[0] % 8);  // 0 means a full last beat
    if ((b.data & mask) !== exp_d)
    begin
      mismatch_o++;
      $display("MISMATCH %0s data: expected %h, actual %h", name_q[0], exp_d, b.data & mask);
    end
    if (b.last !== exp_last)
    begin
      mismatch_o++;
      $display("MISMATCH %0s last: expected %0d, actual %0d", name_q[0], exp_last, b.last);
    end
    if (exp_last && b.last && (b.nbytes !== exp_nb))
    begin
      mismatch_o++;
      $display("MISMATCH %0s nbytes: expected %0d, actual %0d", name_q[0], exp_nb, b.nbytes);
    end
    byte_idx += 8;
    if (b.last || exp_last)
    begin
      void'(name_q.pop_front());  // Frame done, right or wrong
      void'(len_q.pop_front());
      void'(seed_q.pop_front());
      byte_idx = 0;
    end
  endtask

  // Everything sampled mid-cycle, away from both edges
  always @(negedge m_user_clk)
  begin
    if (exp_stb_i)
    begin
      name_q.push_back(exp_name_i);
      len_q.push_back(int'(exp_len_i));
      seed_q.push_back(exp_seed_i);
    end
    if (vchk_stb_i && (vchk_exp_i !== vchk_act_i))
    begin
      mismatch_o++;
      $display("MISMATCH %0s: expected %0d, actual %0d", vchk_name_i, vchk_exp_i, vchk_act_i);
    end
    // Stalled beat must stay put
    if (hold_q && (!rx_valid_i || (rx_beat_i !== held_q)))
    begin
      other_o++;
      $display("ERROR: returned beat changed or vanished while rx_ready_i was low");
    end
    hold_q = rx_valid_i && !rx_ready_i;
    held_q = rx_beat_i;
    if (rx_valid_i && rx_ready_i)
      check_beat(rx_beat_i);  // Taken on the coming edge
    pending_o = len_q.size();
  end

endmodule

`default_nettype wire

// ==== sim/loopback_stimulus.txt ====
# frame name frames bytes seed(hex) ready(0 low,1 high,2 random) cut(beat where valid drops, 0 none)
# drain name | check name near_tx far_rx_good far_tx near_rx_good far_rx_bad
frame fill_small 1 16 8d8b 0 0
frame fill_big 1 256 8d8c 0 0
drain fill_drain
frame conc_20b 20 20 51a3 1 0
frame conc_max 1 253 77e1 1 0
frame rand_ready 8 61 2c4f 2 0
frame underrun 2 40 9e37 1 2
check counters 33 32 32 32 1
